/* sources.f */
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/fetch_ctrl.sv
logic/icache.sv
logic/inst_slots.sv
logic/fetch_top.sv
tests/fetch_sva.sv
tests/fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= fetch_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* tests/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb
    import fetch_pkg::*;
();

    logic  clk;
    logic  rstn;
    logic  stall;
    logic  redirect;
    addr_t redirect_pc;
    inst_t slot0_inst;
    addr_t slot0_pc;
    logic  slot0_valid;
    inst_t slot1_inst;
    addr_t slot1_pc;
    logic  slot1_valid;

    integer seed = 23225;
    string  test_name = "reset";
    int     pairs_checked = 0;

    // reference pipeline state
    fetch_state_t model_state = FS_RESET;
    addr_t        model_pc = 32'd0;
    logic         model_ic_valid = 1'b0;
    addr_t        model_ic_pc = 32'd0;
    logic         model_out_valid = 1'b0;
    addr_t        model_out_pc = 32'd0;

    fetch_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // program table, pair plus slot 1 issue flag
    function automatic pair_t expected_pair(input addr_t pc, output logic flag);
        flag = 1'b0;
        case (pc)
            32'd0: begin
                flag = 1'b1;
                return {32'b0000001010_000000010000_00001_00001,
                        32'b0000001010_000000000001_00010_00010};
            end
            32'd4: return {32'b0000001010_000000000001_00010_00010,
                           32'b0010100010_000000000001_00010_00011};
            32'd8: begin
                flag = 1'b1;
                return {32'b0010100010_000000000001_00010_00011,
                        32'b010111_1111111111111110_00001_00010};
            end
            // r8 increments off the program
            default: return {32'b0000001010_000000000001_01000_01000,
                             32'b0000001010_000000000001_01000_01000};
        endcase
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_inst(input string what, input inst_t exp, input inst_t act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_valid(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // steps on the same edge as the DUT, inputs are stable here
    always @(posedge clk) begin
        if (!rstn) begin
            model_state     = FS_RESET;
            model_pc        = 32'd0;
            model_ic_valid  = 1'b0;
            model_out_valid = 1'b0;
        end else if (model_state == FS_FETCH) begin
            if (!stall) begin
                // pair moves to the slots, current pc enters the cache stage
                model_out_valid = model_ic_valid;
                model_out_pc    = model_ic_pc;
                model_ic_valid  = 1'b1;
                model_ic_pc     = model_pc;
            end
            if (redirect) begin
                model_pc    = redirect_pc;
                model_state = FS_REDIRECT;
            end else if (!stall) begin
                model_pc = model_pc + 32'd8;
            end
        end else begin
            // settle or flush cycle, nothing in flight survives
            model_ic_valid  = 1'b0;
            model_out_valid = 1'b0;
            model_state     = FS_FETCH;
        end
    end

    // sample mid-cycle
    always @(negedge clk) begin
        pair_t pair;
        logic  flag;
        pair = expected_pair(model_out_pc, flag);
        check_valid("slot0_valid", model_out_valid, slot0_valid);
        check_valid("slot1_valid", model_out_valid & flag, slot1_valid);
        if (model_out_valid) begin
            check_addr("slot0_pc", model_out_pc, slot0_pc);
            check_addr("slot1_pc", model_out_pc + 32'd4, slot1_pc);
            check_inst("slot0_inst", pair[PAIR_W-1:INST_W], slot0_inst);
            check_inst("slot1_inst", pair[INST_W-1:0], slot1_inst);
            pairs_checked++;
        end
    end

    task automatic wait_valid(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!slot0_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!slot0_valid) begin
            $display("timeout in %s: no valid output after %0d cycles", test_name, limit);
            abort_run();
        end
    endtask

    // returns right after the flush edge
    task automatic pulse_redirect(input addr_t target);
        @(posedge clk);
        #1;
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        @(posedge clk);
    endtask

    // first valid pair is the target, the next one follows by a pair step
    task automatic check_target(input addr_t target);
        pair_t pair;
        logic  flag;
        wait_valid(10);
        pair = expected_pair(target, flag);
        check_addr("slot0_pc", target, slot0_pc);
        check_valid("slot1_valid", flag, slot1_valid);
        @(negedge clk);
        check_addr("slot0_pc", target + 32'd8, slot0_pc);
    endtask

    initial begin
        rstn        = 1'b0;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = 32'd0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_name = "sequential";
        wait_valid(10);
        for (int i = 0; i < 6; i++) begin
            check_addr("slot0_pc", addr_t'(i * 8), slot0_pc);
            @(negedge clk);
        end

        test_name = "redirect";
        pulse_redirect(32'd4);
        check_target(32'd4);

        // stall only, the model catches loss, repeats and drift
        test_name = "random_stall";
        repeat (200) begin
            @(posedge clk);
            #1;
            stall = (($random(seed) & 7) < 3);
        end
        @(posedge clk);
        #1;

        test_name = "stall_redirect";
        stall = 1'b1;
        pulse_redirect(32'd8);
        repeat (3) @(posedge clk);
        #1;
        stall = 1'b0;
        check_target(32'd8);

        test_name = "back_to_back";
        @(posedge clk);
        #1;
        redirect    = 1'b1;
        redirect_pc = 32'd24;
        @(posedge clk);
        #1;
        // lands in the flush cycle and is dropped
        redirect_pc = 32'd0;
        @(posedge clk);
        #1;
        redirect_pc = 32'd4;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        @(posedge clk);
        check_target(32'd4);

        repeat (5) @(negedge clk);
        if (pairs_checked < 20) begin
            $display("only %0d valid output cycles were compared", pairs_checked);
            abort_run();
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* tests/fetch_sva.sv */
`timescale 1ns/10ps

module fetch_sva
    import fetch_pkg::*;
(
    input logic  clk,
    input logic  rstn,
    input logic  stall,
    input logic  flush,
    input logic  advance,
    input logic  load,
    input inst_t slot0_inst,
    input addr_t slot0_pc,
    input logic  slot0_valid,
    input inst_t slot1_inst,
    input addr_t slot1_pc,
    input logic  slot1_valid
);

    // single flush cycle per redirect or settle
    flush_one_cycle: assert property (@(posedge clk) disable iff (!rstn) flush |=> !flush)
        else $error("flush high for two cycles in a row");

    // slot 1 never issues alone
    slot1_needs_slot0: assert property (@(posedge clk) disable iff (!rstn)
        slot1_valid |-> slot0_valid)
        else $error("slot1_valid without slot0_valid");

    // outputs frozen under back-pressure unless flushed
    hold_on_stall: assert property (@(posedge clk) disable iff (!rstn)
        (stall && !flush) |=> $stable({slot0_inst, slot0_pc, slot0_valid,
                                      slot1_inst, slot1_pc, slot1_valid}))
        else $error("slot outputs changed while stalled");

    // settle cycle, pc must not move yet
    quiet_after_reset: assert property (@(posedge clk) $rose(rstn) |-> (!advance && !load))
        else $error("advance or load high right after reset release");

endmodule

bind fetch_top fetch_sva u_fetch_sva (.*);

/* logic/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  stall,
    input  logic  redirect,
    input  addr_t redirect_pc,
    output inst_t slot0_inst,
    output addr_t slot0_pc,
    output logic  slot0_valid,
    output inst_t slot1_inst,
    output addr_t slot1_pc,
    output logic  slot1_valid
);

    // control strobes
    logic  advance;
    logic  load;
    logic  flush;

    // fetch address
    addr_t pc;

    // cache stage
    pair_t ir_reg;
    logic  flag_reg;
    logic  icache_valid_reg;

    // sequencing, sees stall to withhold advance
    fetch_ctrl u_fetch_ctrl (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall),
        .redirect (redirect),
        .advance  (advance),
        .load     (load),
        .flush    (flush)
    );

    // pc counter, never sees stall
    pc_gen u_pc_gen (
        .clk         (clk),
        .rstn        (rstn),
        .advance     (advance),
        .load        (load),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    // first pipeline stage
    icache u_icache (
        .clk              (clk),
        .rstn             (rstn),
        .flush            (flush),
        .stall            (stall),
        .pc               (pc),
        .ir_reg           (ir_reg),
        .flag_reg         (flag_reg),
        .icache_valid_reg (icache_valid_reg)
    );

    // second stage, drives the slot outputs
    inst_slots u_inst_slots (
        .clk              (clk),
        .rstn             (rstn),
        .flush            (flush),
        .stall            (stall),
        .pc               (pc),
        .ir_reg           (ir_reg),
        .flag_reg         (flag_reg),
        .icache_valid_reg (icache_valid_reg),
        .slot0_inst       (slot0_inst),
        .slot1_inst       (slot1_inst),
        .slot0_pc         (slot0_pc),
        .slot1_pc         (slot1_pc),
        .slot0_valid      (slot0_valid),
        .slot1_valid      (slot1_valid)
    );

endmodule

/* logic/inst_slots.sv */
`timescale 1ns/10ps

module inst_slots
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  flush,
    input  logic  stall,
    input  addr_t pc,
    input  pair_t ir_reg,
    input  logic  flag_reg,
    input  logic  icache_valid_reg,
    output inst_t slot0_inst,
    output inst_t slot1_inst,
    output addr_t slot0_pc,
    output addr_t slot1_pc,
    output logic  slot0_valid,
    output logic  slot1_valid
);

    // address of the pair now held in ir_reg
    addr_t pc_q;

    // pc stage, in step with the cache register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q <= RESET_PC;
        end else if (flush) begin
            pc_q <= RESET_PC;
        end else if (!stall) begin
            pc_q <= pc;
        end
    end

    // output stage, splits the pair
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot0_inst  <= '0;
            slot1_inst  <= '0;
            slot0_pc    <= RESET_PC;
            slot1_pc    <= RESET_PC;
            slot0_valid <= 1'b0;
            slot1_valid <= 1'b0;
        end else if (flush) begin
            slot0_inst  <= '0;
            slot1_inst  <= '0;
            slot0_pc    <= RESET_PC;
            slot1_pc    <= RESET_PC;
            slot0_valid <= 1'b0;
            slot1_valid <= 1'b0;
        end else if (!stall) begin
            // older instr in upper half
            slot0_inst  <= ir_reg[PAIR_W-1:INST_W];
            slot1_inst  <= ir_reg[INST_W-1:0];
            slot0_pc    <= pc_q;
            slot1_pc    <= pc_q + SLOT_STEP;
            slot0_valid <= icache_valid_reg;
            // slot 1 only when the pair allows dual issue
            slot1_valid <= icache_valid_reg & flag_reg;
        end
    end

endmodule

/* logic/icache.sv */
`timescale 1ns/10ps

module icache
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  flush,
    input  logic  stall,
    input  addr_t pc,
    output pair_t ir_reg,
    output logic  flag_reg,
    output logic  icache_valid_reg
);

    // lookup result before the register
    pair_t ir;
    logic  flag;

    // hard-wired program table indexed by pc
    always_comb begin
        case (pc)
            32'd0: begin
                ir   = PROG_PAIR_0;
                flag = PROG_FLAG_0;
            end
            32'd4: begin
                ir   = PROG_PAIR_4;
                flag = PROG_FLAG_4;
            end
            32'd8: begin
                ir   = PROG_PAIR_8;
                flag = PROG_FLAG_8;
            end
            // anything else hits the r8 filler
            default: begin
                ir   = NOP_PAIR;
                flag = 1'b0;
            end
        endcase
    end

    // registered output one cycle after the pc
    // flush beats stall
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ir_reg           <= '0;
            flag_reg         <= 1'b0;
            icache_valid_reg <= 1'b0;
        end else if (flush) begin
            ir_reg           <= '0;
            flag_reg         <= 1'b0;
            icache_valid_reg <= 1'b0;
        end else if (!stall) begin
            ir_reg           <= ir;
            flag_reg         <= flag;
            // every pc hits either the program or the filler
            icache_valid_reg <= 1'b1;
        end
    end

endmodule

/* logic/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic stall,
    input  logic redirect,
    output logic advance,
    output logic load,
    output logic flush
);

    fetch_state_t state;
    fetch_state_t state_next;

    // next state
    always_comb begin
        state_next = state;
        case (state)
            // one settling cycle after reset release
            FS_RESET: state_next = FS_FETCH;
            FS_FETCH: begin
                // redirect accepted even under stall
                if (redirect) begin
                    state_next = FS_REDIRECT;
                end
            end
            // single flush cycle, then back to fetch
            FS_REDIRECT: state_next = FS_FETCH;
            default: state_next = FS_RESET;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= FS_RESET;
        end else begin
            state <= state_next;
        end
    end

    // step pc only in steady fetch without back-pressure
    assign advance = (state == FS_FETCH) && !stall;

    // redirect outside fetch state is dropped
    assign load = (state == FS_FETCH) && redirect;

    // redirect state clears the wrong-path pairs in flight.
    // the settling state also clears the pair looked up at RESET_PC
    // while the pc was still held, otherwise pc 0 would issue twice
    assign flush = (state == FS_REDIRECT) || (state == FS_RESET);

endmodule

/* logic/pc_gen.sv */
`timescale 1ns/10ps

module pc_gen
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  advance,
    input  logic  load,
    input  addr_t redirect_pc,
    output addr_t pc
);

    // next fetch address
    addr_t pc_next;

    always_comb begin
        // hold by default
        pc_next = pc;
        if (load) begin
            // redirect wins over sequential step
            pc_next = redirect_pc;
        end else if (advance) begin
            // one pair further
            pc_next = pc + PAIR_STEP;
        end
    end

    // fetch address register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // no stall input here
    // fetch_ctrl drops advance while decode is stalled,
    // so the pc freezes together with the cache stage

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // widths
    localparam int ADDR_W = 32;
    localparam int INST_W = 32;
    localparam int PAIR_W = 2 * INST_W;

    // byte address, also used for redirect targets
    typedef logic [ADDR_W-1:0] addr_t;
    // one instruction word
    typedef logic [INST_W-1:0] inst_t;
    // older instr in upper half, younger in lower half
    typedef logic [PAIR_W-1:0] pair_t;

    typedef enum logic [1:0] {
        FS_RESET    = 2'd0,
        FS_FETCH    = 2'd1,
        FS_REDIRECT = 2'd2
    } fetch_state_t;

    // pc step per pair, and slot 1 offset from slot 0
    localparam addr_t PAIR_STEP = 32'd8;
    localparam addr_t SLOT_STEP = 32'd4;
    localparam addr_t RESET_PC  = 32'd0;

    // addi r8,r8,1 twice, returned off the program
    localparam pair_t NOP_PAIR =
        {32'b0000001010_000000000001_01000_01000, 32'b0000001010_000000000001_01000_01000};

    // addi r1,r1,16 / addi r2,r2,1
    localparam pair_t PROG_PAIR_0 =
        {32'b0000001010_000000010000_00001_00001, 32'b0000001010_000000000001_00010_00010};
    // addi r2,r2,1 / ld.w r3,r2,1
    localparam pair_t PROG_PAIR_4 =
        {32'b0000001010_000000000001_00010_00010, 32'b0010100010_000000000001_00010_00011};
    // ld.w r3,r2,1 / bne r2,r1,-2
    localparam pair_t PROG_PAIR_8 =
        {32'b0010100010_000000000001_00010_00011, 32'b010111_1111111111111110_00001_00010};

    // slot 1 issue permission per pair
    localparam logic PROG_FLAG_0 = 1'b1;
    localparam logic PROG_FLAG_4 = 1'b0;
    localparam logic PROG_FLAG_8 = 1'b1;

endpackage
